/* Makefile */
SIM      = verilator
TOP      = tb_pe_ctrl
FILELIST = pe_ctrl.f
FLAGS    = --binary --timing -Wno-fatal -j 0
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, fail if the log reports a failure"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@if ! grep -q "Test OK" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)

/* bench/tb_pe_ctrl.sv */
/* PE control unit testbench
   directed tests with an AXI master engine model on the memory side */
`timescale 1ns/10ps
`default_nettype none

module tb_pe_ctrl import pe_ctrl_pkg::*; ();

  localparam int MAX_CYCLES = 5000;

  logic               CLK = 1'b0;
  logic               RESETN;
  psum_t              acc_params;
  psum_t              mem_ctrl;
  psum_t              psum_base_addr;
  psum_t              output_base_addr;
  psum_t              pe_status;
  logic               in_act_valid;
  psum_t              out_psum_in;
  logic               resetn_mac_ctrl;
  logic               stall_ctrl;
  logic [0:PE_COLS-1] add_mux_ctrl [0:PE_ROWS-1];
  logic [3:0]         row_out_mux_ctrl [0:PE_ROWS-1];
  logic [2:0]         psum_out_mux_ctrl;
  psum_t              in_psum_out;
  psum_t              m_axi_rdata;
  logic               m_axi_rvalid_rready;
  logic               m_axi_wvalid_wready;
  logic               txn_done;
  logic               axi_error;
  psum_t              m_axi_wdata;
  logic               init_axi_rd_txn;
  logic               init_axi_wr_txn;
  psum_t              m_target_ar_addr;
  psum_t              m_target_aw_addr;

  logic [31:0] lfsr_state = 32'h14ca;
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  logic        inject_error = 1'b0;
  psum_t       rd_mem [48];
  psum_t       rd_addr_log [$];
  psum_t       wr_addr_log [$];
  psum_t       wr_cap [$];

  pe_ctrl_top dut_i (
    .CLK (CLK), .RESETN (RESETN), .acc_params (acc_params), .mem_ctrl (mem_ctrl),
    .psum_base_addr (psum_base_addr), .output_base_addr (output_base_addr),
    .pe_status (pe_status), .in_act_valid (in_act_valid), .out_psum_in (out_psum_in),
    .resetn_mac_ctrl (resetn_mac_ctrl), .stall_ctrl (stall_ctrl),
    .add_mux_ctrl (add_mux_ctrl), .row_out_mux_ctrl (row_out_mux_ctrl),
    .psum_out_mux_ctrl (psum_out_mux_ctrl), .in_psum_out (in_psum_out),
    .m_axi_rdata (m_axi_rdata), .m_axi_rvalid_rready (m_axi_rvalid_rready),
    .m_axi_wvalid_wready (m_axi_wvalid_wready), .txn_done (txn_done),
    .axi_error (axi_error), .m_axi_wdata (m_axi_wdata),
    .init_axi_rd_txn (init_axi_rd_txn), .init_axi_wr_txn (init_axi_wr_txn),
    .m_target_ar_addr (m_target_ar_addr), .m_target_aw_addr (m_target_aw_addr)
  );

  always #10 CLK = ~CLK;

  always @(posedge CLK) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, a test never finished", cycles);
      $display("Test FAILED");
      $finish;
    end
  end

  // fibonacci LFSR with taps 32 22 2 1 stepped once per bit
  function automatic psum_t rand_bits(input int n);
    psum_t r;
    logic  fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      r          = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic psum_t cfg_word(input logic [3:0] r, input logic [3:0] s,
                                     input logic [3:0] tile, input logic valid,
                                     input logic start);
    psum_t w;
    w        = '0;
    w[3:0]   = r;
    w[7:4]   = s;
    w[15:12] = tile;
    w[30]    = start;
    w[31]    = valid;
    return w;
  endfunction

  task automatic compare(input string name, input psum_t got, input psum_t expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("[ERROR] %s: got %h, expected %h", name, got, expected);
    end
  endtask

  task automatic step_clock();
    @(posedge CLK);
    #2;
  endtask

  task automatic wait_status_bit(input int pos);
    while (pe_status[pos] !== 1'b1) begin
      step_clock();
    end
  endtask

  task automatic pulse_mem_ctrl(input int pos);
    mem_ctrl[pos] = 1'b1;
    step_clock();
    mem_ctrl[pos] = 1'b0;
    step_clock();
  endtask

  // AXI master engine model
  task automatic finish_burst(input logic last);
    step_clock();
    m_axi_rvalid_rready = 1'b0;
    m_axi_wvalid_wready = 1'b0;
    txn_done            = 1'b1;
    axi_error           = inject_error && last;
    step_clock();
    txn_done  = 1'b0;
    axi_error = 1'b0;
  endtask

  task automatic serve_read(input psum_t addr);
    int base;
    base = int'((addr - psum_base_addr) >> 2);
    rd_addr_log.push_back(addr);
    for (int beat = 0; beat < 16; beat++) begin
      step_clock();
      // occasional gap between beats
      if (rand_bits(1) != 0) begin
        m_axi_rvalid_rready = 1'b0;
        step_clock();
      end
      m_axi_rdata         = rd_mem[(base + beat) % 48];
      m_axi_rvalid_rready = 1'b1;
    end
    finish_burst(addr == psum_base_addr + 32'd128);
  endtask

  task automatic serve_write(input psum_t addr);
    wr_addr_log.push_back(addr);
    for (int beat = 0; beat < 16; beat++) begin
      step_clock();
      m_axi_wvalid_wready = 1'b1;
      wr_cap.push_back(m_axi_wdata);
    end
    finish_burst(addr == output_base_addr + 32'd128);
  endtask

  initial begin
    m_axi_rdata         = '0;
    m_axi_rvalid_rready = 1'b0;
    m_axi_wvalid_wready = 1'b0;
    txn_done            = 1'b0;
    axi_error           = 1'b0;
    forever begin
      @(negedge CLK);
      if (init_axi_rd_txn === 1'b1) begin
        serve_read(m_target_ar_addr);
      end else if (init_axi_wr_txn === 1'b1) begin
        serve_write(m_target_aw_addr);
      end
    end
  end

  // only the first rows carry the column pattern
  task automatic verify_mux(input logic [0:PE_COLS-1] add_row, input int rows,
                            input int row_sel, input int psum_sel);
    for (int row = 0; row < PE_ROWS; row++) begin
      compare($sformatf("add_mux_ctrl[%0d]", row), psum_t'(add_mux_ctrl[row]),
              (row < rows) ? psum_t'(add_row) : psum_t'(0));
      compare($sformatf("row_out_mux_ctrl[%0d]", row), psum_t'(row_out_mux_ctrl[row]),
              psum_t'(row_sel));
    end
    compare("psum_out_mux_ctrl", psum_t'(psum_out_mux_ctrl), psum_t'(psum_sel));
  endtask

  task automatic reset_defaults();
    RESETN = 1'b0;
    repeat (8) @(posedge CLK);
    #2;
    RESETN = 1'b1;
    step_clock();
    compare("init_axi_rd_txn", psum_t'(init_axi_rd_txn), '0);
    compare("init_axi_wr_txn", psum_t'(init_axi_wr_txn), '0);
    compare("pe_status", pe_status, '0);
    compare("resetn_mac_ctrl", psum_t'(resetn_mac_ctrl), 32'd1);
    compare("stall_ctrl", psum_t'(stall_ctrl), 32'd1);
    verify_mux(5'b00000, 0, 0, 0);
  endtask

  task automatic load_config();
    acc_params = cfg_word(4'd3, 4'd2, 4'd4, 1'b1, 1'b0);
    step_clock();
    verify_mux(5'b11000, 3, 3, 2);
    // fields change without valid so the settings must hold
    acc_params = cfg_word(4'd5, 4'd5, 4'd8, 1'b0, 1'b0);
    step_clock();
    step_clock();
    verify_mux(5'b11000, 3, 3, 2);
    acc_params = cfg_word(4'd3, 4'd2, 4'd4, 1'b0, 1'b0);
  endtask

  task automatic fetch_psums();
    rd_addr_log.delete();
    mem_ctrl[MEM_BUF_PSUM_BIT] = 1'b1;
    step_clock();
    mem_ctrl[MEM_BUF_PSUM_BIT] = 1'b0;
    compare("pe_status[0]", psum_t'(pe_status[STAT_PSUMS_BUFFERED]), '0);
    compare("pe_status[16]", psum_t'(pe_status[STAT_PSUM_ERROR]), '0);
    wait_status_bit(STAT_PSUMS_BUFFERED);
    compare("read burst count", psum_t'(rd_addr_log.size()), 32'd3);
    for (int k = 0; k < rd_addr_log.size() && k < 3; k++) begin
      compare($sformatf("m_target_ar_addr[%0d]", k), rd_addr_log[k],
              psum_base_addr + psum_t'(64 * k));
    end
  endtask

  task automatic fetch_and_drain();
    int   idx;
    logic v;
    for (int i = 0; i < 48; i++) begin
      rd_mem[i] = rand_bits(32);
    end
    fetch_psums();
    // flush and refetch new data over the old words
    pulse_mem_ctrl(MEM_CLR_PSUM_BIT);
    for (int i = 0; i < 48; i++) begin
      rd_mem[i] = rand_bits(32);
    end
    fetch_psums();
    compare("pe_status[16]", psum_t'(pe_status[STAT_PSUM_ERROR]), '0);
    idx = 0;
    while (idx < 48) begin
      compare($sformatf("in_psum_out[%0d]", idx), in_psum_out, rd_mem[idx]);
      v            = (rand_bits(1) != 0);
      in_act_valid = v;
      step_clock();
      if (v) begin
        idx++;
      end
    end
    in_act_valid = 1'b0;
  endtask

  task automatic run_mac_and_write();
    psum_t cap_vals [12];
    int    nvalid;
    logic  v;
    wr_cap.delete();
    wr_addr_log.delete();
    acc_params = cfg_word(4'd3, 4'd2, 4'd4, 1'b0, 1'b1);
    repeat (2) begin
      @(negedge CLK);
      compare("stall_ctrl", psum_t'(stall_ctrl), 32'd1);
      step_clock();
    end
    acc_params = cfg_word(4'd3, 4'd2, 4'd4, 1'b0, 1'b0);
    // pipe fill plus tile x R counted cycles
    nvalid = 0;
    while (nvalid < 14) begin
      v            = (rand_bits(1) != 0);
      in_act_valid = v;
      @(negedge CLK);
      compare("stall_ctrl", psum_t'(stall_ctrl), psum_t'(!v));
      step_clock();
      if (v) begin
        nvalid++;
      end
    end
    for (int k = 0; k < 12; k++) begin
      cap_vals[k]  = rand_bits(32);
      out_psum_in  = cap_vals[k];
      in_act_valid = (k != 0) && (rand_bits(1) != 0);
      @(negedge CLK);
      compare("stall_ctrl", psum_t'(stall_ctrl), '0);
      step_clock();
    end
    in_act_valid = 1'b0;
    out_psum_in  = '0;
    step_clock();
    compare("pe_status[1]", psum_t'(pe_status[STAT_OUTPUT_WRITTEN]), '0);
    wait_status_bit(STAT_OUTPUT_WRITTEN);
    compare("write burst count", psum_t'(wr_addr_log.size()), 32'd3);
    for (int k = 0; k < wr_addr_log.size() && k < 3; k++) begin
      compare($sformatf("m_target_aw_addr[%0d]", k), wr_addr_log[k],
              output_base_addr + psum_t'(64 * k));
    end
    for (int k = 0; k < wr_cap.size() && k < 12; k++) begin
      compare($sformatf("m_axi_wdata[%0d]", k), wr_cap[k], cap_vals[k]);
    end
  endtask

  task automatic inject_errors();
    inject_error = 1'b1;
    fetch_psums();
    compare("pe_status[16]", psum_t'(pe_status[STAT_PSUM_ERROR]), 32'd1);
    run_mac_and_write();
    compare("pe_status[17]", psum_t'(pe_status[STAT_OUTPUT_ERROR]), 32'd1);
    inject_error = 1'b0;
    // a fresh fetch edge drops the read error
    pulse_mem_ctrl(MEM_CLR_PSUM_BIT);
    fetch_psums();
    compare("pe_status[16]", psum_t'(pe_status[STAT_PSUM_ERROR]), '0);
  endtask

  initial begin
    RESETN           = 1'b0;
    acc_params       = '0;
    mem_ctrl         = '0;
    psum_base_addr   = 32'h0001_0000;
    output_base_addr = 32'h0002_4000;
    in_act_valid     = 1'b0;
    out_psum_in      = '0;
    reset_defaults();
    load_config();
    fetch_and_drain();
    run_mac_and_write();
    inject_errors();
    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* pe_ctrl.f */
source/pe_ctrl_pkg.sv
source/psum_fifo_if.sv
source/sync_fifo.sv
source/cfg_decoder.sv
source/psum_fetch.sv
source/mac_sequencer.sv
source/output_writer.sv
source/pe_ctrl_top.sv
bench/tb_pe_ctrl.sv

/* source/cfg_decoder.sv */
/* cfg_decoder
   splits the parameter word, forms the soft reset and start pulse,
   and registers the MAC array mux settings */
`timescale 1ns/10ps
`default_nettype none

module cfg_decoder import pe_ctrl_pkg::*; (
  input  logic               CLK,
  input  logic               RESETN,
  input  psum_t              acc_params,
  output acc_cfg_t           cfg,
  output logic               rst_n_all,
  output logic               start_pulse,
  output logic [0:PE_COLS-1] add_mux_ctrl [0:PE_ROWS-1],
  output logic [3:0]         row_out_mux_ctrl [0:PE_ROWS-1],
  output logic [2:0]         psum_out_mux_ctrl
);

  logic start_q;

  assign cfg = '{
    tile: acc_params[TILE_LSB +: FIELD_W],
    s:    acc_params[S_LSB +: FIELD_W],
    r:    acc_params[R_LSB +: FIELD_W]
  };

  // soft reset bit holds everything below in reset
  assign rst_n_all = RESETN & ~acc_params[PARAM_RESET_BIT];

  // start rising edge
  always_ff @(posedge CLK) begin
    if (!rst_n_all) begin
      start_q     <= 1'b0;
      start_pulse <= 1'b0;
    end else begin
      start_q     <= acc_params[PARAM_START_BIT];
      start_pulse <= acc_params[PARAM_START_BIT] & ~start_q;
    end
  end

  // mux settings load only with the valid bit, hold otherwise
  always_ff @(posedge CLK) begin
    if (!rst_n_all) begin
      for (int row = 0; row < PE_ROWS; row++) begin
        add_mux_ctrl[row]     <= '0;
        row_out_mux_ctrl[row] <= '0;
      end
      psum_out_mux_ctrl <= '0;
    end else if (acc_params[PARAM_VALID_BIT]) begin
      for (int row = 0; row < PE_ROWS; row++) begin
        // first S columns of the first R rows add
        for (int col = 0; col < PE_COLS; col++) begin
          add_mux_ctrl[row][col] <= (col < int'(cfg.s)) && (row < int'(cfg.r));
        end
        row_out_mux_ctrl[row] <= cfg.tile - 4'd1;
      end
      // last active row feeds the psum output
      psum_out_mux_ctrl <= 3'(cfg.r - 4'd1);
    end
  end

endmodule

`default_nettype wire

/* source/mac_sequencer.sv */
/* mac_sequencer
   steps the MAC array through pipe fill and tile x R counts on valid
   activations, then captures the array's output psums */
`timescale 1ns/10ps
`default_nettype none

module mac_sequencer import pe_ctrl_pkg::*; (
  input  logic        CLK,
  input  logic        rst_n,
  input  acc_cfg_t    cfg,
  input  logic        start_pulse,
  input  logic        in_act_valid,
  input  psum_t       out_psum_in,
  input  psum_t       mem_ctrl,
  output logic        stall_ctrl,
  output logic        out_ready,
  psum_fifo_if.reader psum_q,
  psum_fifo_if.writer out_q
);

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_RUN,
    SEQ_CAPTURE
  } seq_state_t;

  seq_state_t state;
  logic [$clog2(MAC_PIPE_DEPTH+1)-1:0] pipe_cnt;
  logic [FIELD_W-1:0]   col_cnt;
  logic [FIELD_W-1:0]   row_cnt;
  logic [2*FIELD_W-1:0] cap_cnt;
  logic [2*FIELD_W-1:0] cap_limit;
  logic                 clr_q;

  assign cap_limit = (2*FIELD_W)'(cfg.tile) * (2*FIELD_W)'(cfg.r);

  // array never stalls once outputs are being captured
  assign stall_ctrl = ~in_act_valid & (state != SEQ_CAPTURE);

  // psums stream into the array with each valid activation
  assign psum_q.rd = in_act_valid & ~psum_q.empty;

  assign out_q.wr      = (state == SEQ_CAPTURE);
  assign out_q.wr_data = out_psum_in;
  assign out_q.clear   = mem_ctrl[MEM_CLR_OUT_BIT] & ~clr_q;

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state     <= SEQ_IDLE;
      pipe_cnt  <= '0;
      col_cnt   <= '0;
      row_cnt   <= '0;
      cap_cnt   <= '0;
      out_ready <= 1'b0;
      clr_q     <= 1'b0;
    end else begin
      clr_q     <= mem_ctrl[MEM_CLR_OUT_BIT];
      out_ready <= 1'b0;
      case (state)
        SEQ_IDLE: begin
          if (start_pulse) begin
            pipe_cnt <= '0;
            col_cnt  <= '0;
            row_cnt  <= '0;
            cap_cnt  <= '0;
            state    <= SEQ_RUN;
          end
        end
        SEQ_RUN: begin
          // counters hold while activations are invalid
          if (in_act_valid) begin
            if (pipe_cnt < MAC_PIPE_DEPTH) begin
              pipe_cnt <= pipe_cnt + 1'b1;
            end else if (col_cnt < cfg.tile - 4'd1) begin
              col_cnt <= col_cnt + 1'b1;
            end else begin
              col_cnt <= '0;
              if (row_cnt < cfg.r - 4'd1) begin
                row_cnt <= row_cnt + 1'b1;
              end else begin
                row_cnt <= '0;
                state   <= SEQ_CAPTURE;
              end
            end
          end
        end
        SEQ_CAPTURE: begin
          if (cap_cnt == cap_limit - 1'b1) begin
            cap_cnt   <= '0;
            out_ready <= 1'b1;
            state     <= SEQ_IDLE;
          end else begin
            cap_cnt <= cap_cnt + 1'b1;
          end
        end
        default: state <= SEQ_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/output_writer.sv */
/* output_writer
   drains the output FIFO to memory in write bursts through the AXI
   master engine and keeps the output status flags */
`timescale 1ns/10ps
`default_nettype none

module output_writer import pe_ctrl_pkg::*; (
  input  logic        CLK,
  input  logic        rst_n,
  input  logic        out_ready,
  input  psum_t       output_base_addr,
  input  logic        m_axi_wvalid_wready,
  input  logic        txn_done,
  input  logic        axi_error,
  output logic        init_axi_wr_txn,
  output psum_t       m_target_aw_addr,
  output psum_t       m_axi_wdata,
  output logic        output_written,
  output logic        output_write_error,
  psum_fifo_if.reader out_q
);

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_ISSUE,
    WR_WAIT,
    WR_FINISH
  } wr_state_t;

  wr_state_t state;
  logic [$clog2(OUT_BURSTS+1)-1:0] burst_idx;

  // engine reads the FIFO head directly
  assign m_axi_wdata = out_q.rd_data;

  // pop on every accepted beat of a burst
  assign out_q.rd = (state == WR_WAIT) && m_axi_wvalid_wready && !out_q.empty;

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state              <= WR_IDLE;
      burst_idx          <= '0;
      init_axi_wr_txn    <= 1'b0;
      m_target_aw_addr   <= '0;
      output_written     <= 1'b0;
      output_write_error <= 1'b0;
    end else begin
      init_axi_wr_txn <= 1'b0;
      case (state)
        WR_IDLE: begin
          if (out_ready) begin
            output_written     <= 1'b0;
            output_write_error <= 1'b0;
            burst_idx          <= '0;
            state              <= WR_ISSUE;
          end
        end
        WR_ISSUE: begin
          init_axi_wr_txn  <= 1'b1;
          m_target_aw_addr <= output_base_addr + psum_t'(burst_idx * BURST_BYTES);
          state            <= WR_WAIT;
        end
        WR_WAIT: begin
          if (txn_done) begin
            if (axi_error) begin
              output_write_error <= 1'b1;
            end
            if (burst_idx == OUT_BURSTS - 1) begin
              output_written <= 1'b1;
            end
            burst_idx <= burst_idx + 1'b1;
            state     <= WR_FINISH;
          end
        end
        WR_FINISH: begin
          // one idle cycle between bursts
          state <= (burst_idx == OUT_BURSTS) ? WR_IDLE : WR_ISSUE;
        end
        default: state <= WR_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/pe_ctrl_pkg.sv */
/* PE control package
   array and bus sizes, register field positions and shared types */
`default_nettype none

package pe_ctrl_pkg;

  // bus and array sizes
  localparam int DATA_W         = 32;
  localparam int BYTE_W         = 8;
  localparam int PE_ROWS        = 5;
  localparam int PE_COLS        = 5;
  localparam int MAC_PIPE_DEPTH = 2;

  // AXI bursts and buffering
  localparam int BURST_LEN   = 16;
  localparam int BURST_BYTES = BURST_LEN * DATA_W / BYTE_W;
  localparam int FIFO_DEPTH  = 64;
  localparam int PSUM_BURSTS = 3;
  localparam int OUT_BURSTS  = 3;

  // parameter word fields
  localparam int FIELD_W         = 4;
  localparam int R_LSB           = 0;
  localparam int S_LSB           = 4;
  localparam int TILE_LSB        = 12;
  localparam int PARAM_RESET_BIT = 29;
  localparam int PARAM_START_BIT = 30;
  localparam int PARAM_VALID_BIT = 31;

  // memory control bits
  localparam int MEM_CLR_OUT_BIT  = 5;
  localparam int MEM_BUF_PSUM_BIT = 6;
  localparam int MEM_CLR_PSUM_BIT = 7;

  // status word bits
  localparam int STAT_PSUMS_BUFFERED = 0;
  localparam int STAT_OUTPUT_WRITTEN = 1;
  localparam int STAT_PSUM_ERROR     = 16;
  localparam int STAT_OUTPUT_ERROR   = 17;

  typedef struct packed {
    logic [FIELD_W-1:0] tile;
    logic [FIELD_W-1:0] s;
    logic [FIELD_W-1:0] r;
  } acc_cfg_t;

  typedef logic [DATA_W-1:0] psum_t;

endpackage

`default_nettype wire

/* source/pe_ctrl_top.sv */
/* PE control unit top
   decoder, psum fetch, MAC sequencer, output writer and their two FIFOs */
`timescale 1ns/10ps
`default_nettype none

module pe_ctrl_top import pe_ctrl_pkg::*; (
  input  logic               CLK,
  input  logic               RESETN,
  input  psum_t              acc_params,
  input  psum_t              mem_ctrl,
  input  psum_t              psum_base_addr,
  input  psum_t              output_base_addr,
  output psum_t              pe_status,
  // MAC array side
  input  logic               in_act_valid,
  input  psum_t              out_psum_in,
  output logic               resetn_mac_ctrl,
  output logic               stall_ctrl,
  output logic [0:PE_COLS-1] add_mux_ctrl [0:PE_ROWS-1],
  output logic [3:0]         row_out_mux_ctrl [0:PE_ROWS-1],
  output logic [2:0]         psum_out_mux_ctrl,
  output psum_t              in_psum_out,
  // AXI master engine
  input  psum_t              m_axi_rdata,
  input  logic               m_axi_rvalid_rready,
  input  logic               m_axi_wvalid_wready,
  input  logic               txn_done,
  input  logic               axi_error,
  output psum_t              m_axi_wdata,
  output logic               init_axi_rd_txn,
  output logic               init_axi_wr_txn,
  output psum_t              m_target_ar_addr,
  output psum_t              m_target_aw_addr
);

  acc_cfg_t cfg;
  logic     rst_n_all;
  logic     start_pulse;
  logic     out_ready;
  logic     psums_buffered;
  logic     psum_buffer_error;
  logic     output_written;
  logic     output_write_error;

  psum_fifo_if psum_q (.rst_n(rst_n_all));
  psum_fifo_if out_q  (.rst_n(rst_n_all));

  assign resetn_mac_ctrl = rst_n_all;
  assign in_psum_out     = psum_q.rd_data;

  assign pe_status = (psum_t'(psums_buffered)     << STAT_PSUMS_BUFFERED)
                   | (psum_t'(output_written)     << STAT_OUTPUT_WRITTEN)
                   | (psum_t'(psum_buffer_error)  << STAT_PSUM_ERROR)
                   | (psum_t'(output_write_error) << STAT_OUTPUT_ERROR);

  cfg_decoder cfg_decoder_i (
    .CLK               (CLK),
    .RESETN            (RESETN),
    .acc_params        (acc_params),
    .cfg               (cfg),
    .rst_n_all         (rst_n_all),
    .start_pulse       (start_pulse),
    .add_mux_ctrl      (add_mux_ctrl),
    .row_out_mux_ctrl  (row_out_mux_ctrl),
    .psum_out_mux_ctrl (psum_out_mux_ctrl)
  );

  psum_fetch psum_fetch_i (
    .CLK                 (CLK),
    .rst_n               (rst_n_all),
    .mem_ctrl            (mem_ctrl),
    .psum_base_addr      (psum_base_addr),
    .m_axi_rdata         (m_axi_rdata),
    .m_axi_rvalid_rready (m_axi_rvalid_rready),
    .txn_done            (txn_done),
    .axi_error           (axi_error),
    .init_axi_rd_txn     (init_axi_rd_txn),
    .m_target_ar_addr    (m_target_ar_addr),
    .psums_buffered      (psums_buffered),
    .psum_buffer_error   (psum_buffer_error),
    .psum_q              (psum_q)
  );

  mac_sequencer mac_sequencer_i (
    .CLK          (CLK),
    .rst_n        (rst_n_all),
    .cfg          (cfg),
    .start_pulse  (start_pulse),
    .in_act_valid (in_act_valid),
    .out_psum_in  (out_psum_in),
    .mem_ctrl     (mem_ctrl),
    .stall_ctrl   (stall_ctrl),
    .out_ready    (out_ready),
    .psum_q       (psum_q),
    .out_q        (out_q)
  );

  output_writer output_writer_i (
    .CLK                 (CLK),
    .rst_n               (rst_n_all),
    .out_ready           (out_ready),
    .output_base_addr    (output_base_addr),
    .m_axi_wvalid_wready (m_axi_wvalid_wready),
    .txn_done            (txn_done),
    .axi_error           (axi_error),
    .init_axi_wr_txn     (init_axi_wr_txn),
    .m_target_aw_addr    (m_target_aw_addr),
    .m_axi_wdata         (m_axi_wdata),
    .output_written      (output_written),
    .output_write_error  (output_write_error),
    .out_q               (out_q)
  );

  sync_fifo #(.DEPTH(FIFO_DEPTH)) psum_fifo_i (
    .CLK (CLK),
    .q   (psum_q)
  );

  sync_fifo #(.DEPTH(FIFO_DEPTH)) out_fifo_i (
    .CLK (CLK),
    .q   (out_q)
  );

endmodule

`default_nettype wire

/* source/psum_fetch.sv */
/* psum_fetch
   issues the psum read bursts through the AXI master engine and fills
   the psum FIFO, keeping the buffered and error flags */
`timescale 1ns/10ps
`default_nettype none

module psum_fetch import pe_ctrl_pkg::*; (
  input  logic        CLK,
  input  logic        rst_n,
  input  psum_t       mem_ctrl,
  input  psum_t       psum_base_addr,
  input  psum_t       m_axi_rdata,
  input  logic        m_axi_rvalid_rready,
  input  logic        txn_done,
  input  logic        axi_error,
  output logic        init_axi_rd_txn,
  output psum_t       m_target_ar_addr,
  output logic        psums_buffered,
  output logic        psum_buffer_error,
  psum_fifo_if.writer psum_q
);

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_ISSUE,
    RD_WAIT,
    RD_FINISH
  } rd_state_t;

  rd_state_t state;
  logic [$clog2(PSUM_BURSTS+1)-1:0] burst_idx;
  logic buf_q;
  logic clr_q;
  logic buf_rise;

  assign buf_rise     = mem_ctrl[MEM_BUF_PSUM_BIT] & ~buf_q;
  assign psum_q.clear = mem_ctrl[MEM_CLR_PSUM_BIT] & ~clr_q;

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state             <= RD_IDLE;
      burst_idx         <= '0;
      buf_q             <= 1'b0;
      clr_q             <= 1'b0;
      init_axi_rd_txn   <= 1'b0;
      m_target_ar_addr  <= '0;
      psums_buffered    <= 1'b0;
      psum_buffer_error <= 1'b0;
    end else begin
      buf_q           <= mem_ctrl[MEM_BUF_PSUM_BIT];
      clr_q           <= mem_ctrl[MEM_CLR_PSUM_BIT];
      init_axi_rd_txn <= 1'b0;
      case (state)
        RD_IDLE: begin
          if (buf_rise) begin
            psums_buffered    <= 1'b0;
            psum_buffer_error <= 1'b0;
            burst_idx         <= '0;
            state             <= RD_ISSUE;
          end
        end
        RD_ISSUE: begin
          init_axi_rd_txn  <= 1'b1;
          m_target_ar_addr <= psum_base_addr + psum_t'(burst_idx * BURST_BYTES);
          state            <= RD_WAIT;
        end
        RD_WAIT: begin
          // engine may stall indefinitely before txn_done
          if (txn_done) begin
            if (axi_error) begin
              psum_buffer_error <= 1'b1;
            end
            if (burst_idx == PSUM_BURSTS - 1) begin
              psums_buffered <= 1'b1;
            end
            burst_idx <= burst_idx + 1'b1;
            state     <= RD_FINISH;
          end
        end
        RD_FINISH: begin
          state <= (burst_idx == PSUM_BURSTS) ? RD_IDLE : RD_ISSUE;
        end
        default: state <= RD_IDLE;
      endcase
      // overflow should never happen with 48 words in a 64 deep FIFO
      if (psum_q.wr && psum_q.full) begin
        psum_buffer_error <= 1'b1;
      end
    end
  end

  // read beats land in the FIFO one cycle later
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      psum_q.wr <= 1'b0;
    end else begin
      psum_q.wr <= (state == RD_WAIT) && m_axi_rvalid_rready;
    end
  end

  always_ff @(posedge CLK) begin
    psum_q.wr_data <= m_axi_rdata;
  end

endmodule

`default_nettype wire

/* source/psum_fifo_if.sv */
/* psum FIFO bus
   write, read, clear and flags of one synchronous FIFO */
`timescale 1ns/10ps
`default_nettype none

interface psum_fifo_if import pe_ctrl_pkg::*; (
  input logic rst_n
);

  logic  wr;
  psum_t wr_data;
  logic  full;
  logic  rd;
  psum_t rd_data;
  logic  empty;
  logic  clear;

  modport writer (output wr, output wr_data, output clear, input full);

  modport reader (output rd, input rd_data, input empty);

  // FIFO side
  modport store (
    input  rst_n, input wr, input wr_data, input rd, input clear,
    output full, output rd_data, output empty
  );

endinterface

`default_nettype wire

/* source/sync_fifo.sv */
/* sync_fifo
   first-word-fall-through circular buffer with count, flags and clear */
`timescale 1ns/10ps
`default_nettype none

module sync_fifo import pe_ctrl_pkg::*; #(
  parameter int DEPTH = FIFO_DEPTH
) (
  input logic         CLK,
  psum_fifo_if.store  q
);

  localparam int AW = $clog2(DEPTH);

  psum_t         mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic          push;
  logic          pop;

  // writes to a full FIFO are dropped
  assign push = q.wr && !q.full;
  assign pop  = q.rd && !q.empty;

  always_ff @(posedge CLK) begin
    if (!q.rst_n || q.clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (push) begin
      mem[wr_ptr] <= q.wr_data;
    end
  end

  // head word always visible
  assign q.rd_data = mem[rd_ptr];
  assign q.full    = (count == (AW+1)'(DEPTH));
  assign q.empty   = (count == '0);

endmodule

`default_nettype wire
